// ==== holo_ctrl_pkg.sv ====
/*
  holo_ctrl shared definitions
  byte and frame widths, UART and SPI timing counts, counter widths,
  receiver state codes and the SPI frame union
*/
`default_nettype none

package holo_ctrl_pkg;

  //////////////////////////////
  // widths and timing counts
  localparam int BYTE_W            = 8;
  localparam int FRAME_W           = 16;
  // short counts for simulation
  localparam int UART_CLKS_PER_BIT = 16;
  localparam int SPI_HALF_CLKS     = 4;
  localparam int RESET_HOLD_CLKS   = 10;
  localparam int REPLY_DEPTH       = 4;
  localparam int REPLY_PTR_W       = 2;

  // derived counter widths
  localparam int REPLY_CNT_W = REPLY_PTR_W + 1;
  localparam int UART_CNT_W  = $clog2(UART_CLKS_PER_BIT);
  localparam int BIT_IDX_W   = $clog2(BYTE_W);
  // start + data + stop
  localparam int UART_BITS   = BYTE_W + 2;
  localparam int UART_BIT_W  = $clog2(UART_BITS);
  localparam int SPI_DIV_W   = $clog2(SPI_HALF_CLKS);
  // one extra half period closes the frame
  localparam int SPI_EDGE_W  = $clog2(2 * FRAME_W + 1);
  localparam int RESET_CNT_W = $clog2(RESET_HOLD_CLKS + 1);

  // uart receiver states
  localparam logic [1:0] RX_IDLE  = 2'd0;
  localparam logic [1:0] RX_START = 2'd1;
  localparam logic [1:0] RX_DATA  = 2'd2;
  localparam logic [1:0] RX_STOP  = 2'd3;

  //////////////////////////////
  // one spi frame, whole word or address/data pair
  typedef union packed {
    logic [FRAME_W-1:0] word;
    struct packed {
      logic [BYTE_W-1:0] addr;
      logic [BYTE_W-1:0] data;
    } pair;
  } spi_frame_u;

endpackage

`default_nettype wire

// ==== spi_xfer_if.sv ====
/*
  spi transfer interface
  joins command pairing, SPI master and reply queue
*/
`timescale 1ns/1ps
`default_nettype none

interface spi_xfer_if
  import holo_ctrl_pkg::*;
();

  // one-cycle start pulse, frame stable with it
  logic              start;
  spi_frame_u        frame;
  // high for the whole frame
  logic              busy;
  // valid from busy falling until next start
  logic [BYTE_W-1:0] rx_byte;

  modport host (output start, output frame, input busy);
  modport dev  (input start, input frame, output busy, output rx_byte);
  modport mon  (input busy, input rx_byte);

endinterface

`default_nettype wire

// ==== uart_rx.sv ====
/*
  UART receiver
  8N1, sampled at mid-bit after a two-flop synchronizer
  one-cycle byte-valid pulse after the middle of the stop bit
*/
`timescale 1ns/1ps
`default_nettype none

module uart_rx
  import holo_ctrl_pkg::*;
(
  input  logic              fpga_clk,
  input  logic              reset_all_cmd_w,
  input  logic              rx_serial_i,
  output logic              rx_valid_o,
  output logic [BYTE_W-1:0] rx_byte_o
);

  logic                  rx_meta_q;
  logic                  rx_sync_q;
  logic [1:0]            state_q;
  logic [UART_CNT_W-1:0] clk_cnt_q;
  logic [BIT_IDX_W-1:0]  bit_idx_q;

  always_ff @(posedge fpga_clk) begin
    // default no byte
    rx_valid_o <= 1'b0;
    if (reset_all_cmd_w) begin
      // line idles high
      rx_meta_q <= 1'b1;
      rx_sync_q <= 1'b1;
      state_q   <= RX_IDLE;
      clk_cnt_q <= '0;
      bit_idx_q <= '0;
    end else begin
      rx_meta_q <= rx_serial_i;
      rx_sync_q <= rx_meta_q;
      case (state_q)
        RX_IDLE: begin
          clk_cnt_q <= '0;
          bit_idx_q <= '0;
          // falling edge of start bit
          if (!rx_sync_q) begin
            state_q <= RX_START;
          end
        end
        RX_START: begin
          // half a bit to land mid start bit
          if (clk_cnt_q == UART_CNT_W'(UART_CLKS_PER_BIT / 2 - 1)) begin
            clk_cnt_q <= '0;
            // glitch, back to idle
            state_q   <= rx_sync_q ? RX_IDLE : RX_DATA;
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        RX_DATA: begin
          if (clk_cnt_q == UART_CNT_W'(UART_CLKS_PER_BIT - 1)) begin
            clk_cnt_q <= '0;
            // lsb first
            rx_byte_o <= {rx_sync_q, rx_byte_o[BYTE_W-1:1]};
            bit_idx_q <= bit_idx_q + 1'b1;
            // all ones means eighth bit
            if (&bit_idx_q) begin
              state_q <= RX_STOP;
            end
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        RX_STOP: begin
          // mid stop bit, byte done
          if (clk_cnt_q == UART_CNT_W'(UART_CLKS_PER_BIT - 1)) begin
            clk_cnt_q  <= '0;
            rx_valid_o <= 1'b1;
            state_q    <= RX_IDLE;
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        default: state_q <= RX_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== uart_tx.sv ====
/*
  UART transmitter
  start bit, eight data bits lsb first, stop bit
  active level covers exactly ten bit times
*/
`timescale 1ns/1ps
`default_nettype none

module uart_tx
  import holo_ctrl_pkg::*;
(
  input  logic              fpga_clk,
  input  logic              reset_all_cmd_w,
  input  logic              tx_start_i,
  input  logic [BYTE_W-1:0] tx_byte_i,
  output logic              tx_active_o,
  output logic              tx_serial_o
);

  logic [UART_BITS-1:0]  shift_q;
  logic [UART_CNT_W-1:0] clk_cnt_q;
  logic [UART_BIT_W-1:0] bit_cnt_q;

  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      tx_active_o <= 1'b0;
      clk_cnt_q   <= '0;
      bit_cnt_q   <= '0;
    end else if (!tx_active_o) begin
      clk_cnt_q <= '0;
      bit_cnt_q <= '0;
      // load stop, data, start
      if (tx_start_i) begin
        tx_active_o <= 1'b1;
        shift_q     <= {1'b1, tx_byte_i, 1'b0};
      end
    end else if (clk_cnt_q == UART_CNT_W'(UART_CLKS_PER_BIT - 1)) begin
      // end of one bit time
      clk_cnt_q <= '0;
      shift_q   <= {1'b1, shift_q[UART_BITS-1:1]};
      if (bit_cnt_q == UART_BIT_W'(UART_BITS - 1)) begin
        tx_active_o <= 1'b0;
      end else begin
        bit_cnt_q <= bit_cnt_q + 1'b1;
      end
    end else begin
      clk_cnt_q <= clk_cnt_q + 1'b1;
    end
  end

  // idle line high
  assign tx_serial_o = tx_active_o ? shift_q[0] : 1'b1;

endmodule

`default_nettype wire

// ==== cmd_pairing.sv ====
/*
  command pairing
  first byte is the address, second the data
  a complete pair starts one SPI frame
*/
`timescale 1ns/1ps
`default_nettype none

module cmd_pairing
  import holo_ctrl_pkg::*;
(
  input  logic              fpga_clk,
  input  logic              reset_all_cmd_w,
  input  logic              rx_valid_i,
  input  logic [BYTE_W-1:0] rx_byte_i,
  spi_xfer_if.host          spi
);

  logic valid_q;
  // one byte waiting for its partner
  logic odd_byte_q;
  logic valid_rise;

  assign valid_rise = rx_valid_i & ~valid_q;

  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      valid_q    <= 1'b0;
      odd_byte_q <= 1'b0;
      spi.start  <= 1'b0;
    end else begin
      valid_q <= rx_valid_i;
      // second byte of a pair, dropped if the master is still busy
      spi.start <= valid_rise & odd_byte_q & ~spi.busy;
      if (valid_rise) begin
        odd_byte_q <= ~odd_byte_q;
      end
    end
  end

  // data moves along into address
  always_ff @(posedge fpga_clk) begin
    if (valid_rise) begin
      spi.frame.pair.addr <= spi.frame.pair.data;
      spi.frame.pair.data <= rx_byte_i;
    end
  end

endmodule

`default_nettype wire

// ==== spi_master.sv ====
/*
  SPI master, mode 0, 16-bit frames
  active-low enable, address byte msb first
  last eight bits received are kept as the reply byte
*/
`timescale 1ns/1ps
`default_nettype none

module spi_master
  import holo_ctrl_pkg::*;
(
  input  logic     fpga_clk,
  input  logic     reset_all_cmd_w,
  input  logic     sout_i,
  output logic     sen_o,
  output logic     sck_o,
  output logic     sdat_o,
  spi_xfer_if.dev  spi
);

  logic [SPI_DIV_W-1:0]  div_cnt_q;
  logic [SPI_EDGE_W-1:0] edge_cnt_q;
  logic [FRAME_W-1:0]    tx_shift_q;
  logic [BYTE_W-1:0]     rx_shift_q;
  logic                  half_tick;
  logic                  last_edge;

  assign half_tick = (div_cnt_q == SPI_DIV_W'(SPI_HALF_CLKS - 1));
  // half period after the final falling sck
  assign last_edge = (edge_cnt_q == SPI_EDGE_W'(2 * FRAME_W));

  //////////////////////////////
  // framing and sck
  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      spi.busy   <= 1'b0;
      sen_o      <= 1'b1;
      sck_o      <= 1'b0;
      div_cnt_q  <= '0;
      edge_cnt_q <= '0;
    end else if (!spi.busy) begin
      div_cnt_q  <= '0;
      edge_cnt_q <= '0;
      if (spi.start) begin
        spi.busy <= 1'b1;
        sen_o    <= 1'b0;
      end
    end else if (half_tick) begin
      div_cnt_q  <= '0;
      edge_cnt_q <= edge_cnt_q + 1'b1;
      if (last_edge) begin
        spi.busy <= 1'b0;
        sen_o    <= 1'b1;
      end else begin
        // even count rises, odd count falls
        sck_o <= ~edge_cnt_q[0];
      end
    end else begin
      div_cnt_q <= div_cnt_q + 1'b1;
    end
  end

  //////////////////////////////
  // shift registers
  always_ff @(posedge fpga_clk) begin
    if (!spi.busy && spi.start) begin
      tx_shift_q <= spi.frame.word;
    end else if (spi.busy && half_tick) begin
      if (last_edge) begin
        spi.rx_byte <= rx_shift_q;
      end else if (!edge_cnt_q[0]) begin
        // sample on rising sck
        rx_shift_q <= {rx_shift_q[BYTE_W-2:0], sout_i};
      end else begin
        // next bit on falling sck
        tx_shift_q <= {tx_shift_q[FRAME_W-2:0], 1'b0};
      end
    end
  end

  // mosi quiet low outside a frame
  assign sdat_o = ~sen_o & tx_shift_q[FRAME_W-1];

endmodule

`default_nettype wire

// ==== reply_queue.sv ====
/*
  reply queue
  four-deep byte store between SPI reply and UART transmit
  written on busy falling, read by a two-step sequencer
*/
`timescale 1ns/1ps
`default_nettype none

module reply_queue
  import holo_ctrl_pkg::*;
(
  input  logic              fpga_clk,
  input  logic              reset_all_cmd_w,
  input  logic              tx_active_i,
  spi_xfer_if.mon           spi,
  output logic              tx_start_o,
  output logic [BYTE_W-1:0] tx_byte_o
);

  logic [BYTE_W-1:0]      store_q [REPLY_DEPTH];
  logic [REPLY_PTR_W-1:0] wr_ptr_q;
  logic [REPLY_PTR_W-1:0] rd_ptr_q;
  logic [REPLY_CNT_W-1:0] fill_cnt_q;
  logic                   busy_q;
  logic                   rd_pend_q;
  logic                   busy_fall;
  logic                   full;
  logic                   empty;
  logic                   wr_en;
  logic                   rd_go;

  assign busy_fall = busy_q & ~spi.busy;
  assign full      = (fill_cnt_q == REPLY_CNT_W'(REPLY_DEPTH));
  assign empty     = (fill_cnt_q == '0);
  // full queue drops the reply
  assign wr_en     = busy_fall & ~full;
  // hold off until the transmitter has taken the last byte
  assign rd_go     = ~empty & ~tx_active_i & ~rd_pend_q & ~tx_start_o;

  //////////////////////////////
  // pointers, count, sequencer
  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      busy_q     <= 1'b0;
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      fill_cnt_q <= '0;
      rd_pend_q  <= 1'b0;
      tx_start_o <= 1'b0;
    end else begin
      busy_q <= spi.busy;
      if (wr_en) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (rd_go) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      fill_cnt_q <= fill_cnt_q + REPLY_CNT_W'(wr_en) - REPLY_CNT_W'(rd_go);
      // read now, start tx next cycle
      rd_pend_q  <= rd_go;
      tx_start_o <= rd_pend_q;
    end
  end

  // storage
  always_ff @(posedge fpga_clk) begin
    if (wr_en) begin
      store_q[wr_ptr_q] <= spi.rx_byte;
    end
    if (rd_go) begin
      tx_byte_o <= store_q[rd_ptr_q];
    end
  end

endmodule

`default_nettype wire

// ==== panel_reset.sv ====
/*
  panel reset stretcher
  active-low reset held for a fixed count after the command drops
*/
`timescale 1ns/1ps
`default_nettype none

module panel_reset
  import holo_ctrl_pkg::*;
(
  input  logic fpga_clk,
  input  logic reset_all_cmd_w,
  output logic slm_reset_n_o
);

  logic [RESET_CNT_W-1:0] hold_cnt_q;

  // reload while commanded, then count down to zero
  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      hold_cnt_q <= RESET_CNT_W'(RESET_HOLD_CLKS);
    end else if (hold_cnt_q != '0) begin
      hold_cnt_q <= hold_cnt_q - 1'b1;
    end
  end

  // low for the command plus the hold count
  assign slm_reset_n_o = ~(reset_all_cmd_w | (hold_cnt_q != '0));

endmodule

`default_nettype wire

// ==== holo_ctrl_top.sv ====
/*
  display controller command path
  host UART bytes paired into SPI frames to the panel
  SPI replies queued back out on UART, plus stretched panel reset
*/
`timescale 1ns/1ps
`default_nettype none

module holo_ctrl_top
  import holo_ctrl_pkg::*;
(
  input  logic fpga_clk,
  input  logic reset_all_cmd_w,
  input  logic uart_rx_i,
  input  logic sout_i,
  output logic uart_tx_o,
  output logic sen_o,
  output logic sck_o,
  output logic sdat_o,
  output logic slm_reset_n_o
);

  logic              rx_valid;
  logic [BYTE_W-1:0] rx_byte;
  logic              tx_start;
  logic [BYTE_W-1:0] tx_byte;
  logic              tx_active;

  spi_xfer_if spi_bus ();

  //////////////////////////////
  // host to panel
  uart_rx u_uart_rx (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .rx_serial_i     (uart_rx_i),
    .rx_valid_o      (rx_valid),
    .rx_byte_o       (rx_byte)
  );

  cmd_pairing u_cmd_pairing (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .rx_valid_i      (rx_valid),
    .rx_byte_i       (rx_byte),
    .spi             (spi_bus.host)
  );

  spi_master u_spi_master (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .sout_i          (sout_i),
    .sen_o           (sen_o),
    .sck_o           (sck_o),
    .sdat_o          (sdat_o),
    .spi             (spi_bus.dev)
  );

  //////////////////////////////
  // panel replies back to host
  reply_queue u_reply_queue (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .tx_active_i     (tx_active),
    .spi             (spi_bus.mon),
    .tx_start_o      (tx_start),
    .tx_byte_o       (tx_byte)
  );

  uart_tx u_uart_tx (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .tx_start_i      (tx_start),
    .tx_byte_i       (tx_byte),
    .tx_active_o     (tx_active),
    .tx_serial_o     (uart_tx_o)
  );

  // panel reset
  panel_reset u_panel_reset (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .slm_reset_n_o   (slm_reset_n_o)
  );

endmodule

`default_nettype wire

// ==== holo_ctrl_chk.sv ====
/*
  SPI framing and reply queue checks
  concurrent assertions bound into spi_master and reply_queue
*/
`timescale 1ns/1ps
`default_nettype none

module holo_ctrl_chk
  import holo_ctrl_pkg::*;
(
  input logic                   fpga_clk,
  input logic                   reset_all_cmd_w,
  input logic                   sen_i,
  input logic                   sck_i,
  input logic                   start_i,
  input logic                   busy_i,
  input logic [REPLY_CNT_W-1:0] fill_cnt_i
);

  // count of failed assertions
  int fail_cnt = 0;

  //////////////////////////////
  // sck parked low outside a frame
  sck_idle_a : assert property (@(posedge fpga_clk) disable iff (reset_all_cmd_w)
    sen_i |-> !sck_i)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("sck_o high while sen_o is inactive");
    end

  // master takes no start mid frame
  start_idle_a : assert property (@(posedge fpga_clk) disable iff (reset_all_cmd_w)
    start_i |-> !busy_i)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("frame start while the SPI master is busy");
    end

  // occupancy bounded by the store
  fill_bound_a : assert property (@(posedge fpga_clk) disable iff (reset_all_cmd_w)
    fill_cnt_i <= REPLY_CNT_W'(REPLY_DEPTH))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("reply queue occupancy above its depth");
    end

endmodule

//////////////////////////////
// framing side, queue count unused
bind spi_master holo_ctrl_chk spi_chk (
  .fpga_clk        (fpga_clk),
  .reset_all_cmd_w (reset_all_cmd_w),
  .sen_i           (sen_o),
  .sck_i           (sck_o),
  .start_i         (spi.start),
  .busy_i          (spi.busy),
  .fill_cnt_i      ('0)
);

// queue side, spi pins held at idle
bind reply_queue holo_ctrl_chk queue_chk (
  .fpga_clk        (fpga_clk),
  .reset_all_cmd_w (reset_all_cmd_w),
  .sen_i           (1'b1),
  .sck_i           (1'b0),
  .start_i         (1'b0),
  .busy_i          (spi.busy),
  .fill_cnt_i      (fill_cnt_q)
);

`default_nettype wire

// ==== tb_holo_ctrl.sv ====
/*
  testbench for the display controller command path
  host UART model, SPI panel model and UART reply receiver
  random bytes from a fixed seed, checked against queued expectations
*/
`timescale 1ns/1ps
`default_nettype none

module tb_holo_ctrl
  import holo_ctrl_pkg::*;
();

  localparam int CLK_PERIOD  = 100;
  localparam int DRIVE_DLY   = 10;
  localparam int SEED        = 32'h130e;
  // one UART byte, start to stop
  localparam int BYTE_CLKS   = (BYTE_W + 2) * UART_CLKS_PER_BIT;
  // enable low for 33 half periods
  localparam int FRAME_CLKS  = (2 * FRAME_W + 1) * SPI_HALF_CLKS;
  localparam int MAX_PAIRS   = 24;
  localparam int CYCLE_LIMIT = MAX_PAIRS * (2 * BYTE_CLKS + FRAME_CLKS + BYTE_CLKS) * 2;

  logic fpga_clk;
  logic reset_all_cmd_w;
  logic uart_rx_i;
  logic sout_i;
  logic uart_tx_o;
  logic sen_o;
  logic sck_o;
  logic sdat_o;
  logic slm_reset_n_o;

  // expected traffic
  logic [FRAME_W-1:0] exp_frames [$];
  logic [BYTE_W-1:0]  exp_replies [$];
  logic               have_addr;
  logic [BYTE_W-1:0]  pend_addr;
  int                 frames_seen = 0;

  holo_ctrl_top UUT (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .uart_rx_i       (uart_rx_i),
    .sout_i          (sout_i),
    .uart_tx_o       (uart_tx_o),
    .sen_o           (sen_o),
    .sck_o           (sck_o),
    .sdat_o          (sdat_o),
    .slm_reset_n_o   (slm_reset_n_o)
  );

  initial begin
    fpga_clk = 1'b0;
    forever #(CLK_PERIOD / 2) fpga_clk = ~fpga_clk;
  end

  //////////////////////////////
  // helpers
  task automatic next_cycle();
    @(posedge fpga_clk);
    #DRIVE_DLY;
  endtask

  task automatic stop_with_failure();
    $display("TEST FAIL");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                          input string what);
    if (actual !== expected) begin
      $display("Error: time %0t: %s, got %0h expected %0h", $time, what, actual, expected);
      stop_with_failure();
    end
  endtask

  function automatic int assert_failures();
    return UUT.u_spi_master.spi_chk.fail_cnt + UUT.u_reply_queue.queue_chk.fail_cnt;
  endfunction

  // serial 8N1 byte, then an idle gap of a byte time or more
  task automatic send_host_byte(input logic [BYTE_W-1:0] data);
    logic [UART_BITS-1:0] bits;
    int                   gap;
    bits = {1'b1, data, 1'b0};
    gap  = BYTE_CLKS + int'($urandom_range(2 * UART_CLKS_PER_BIT, 0));
    for (int i = 0; i < UART_BITS; i++) begin
      uart_rx_i = bits[i];
      repeat (UART_CLKS_PER_BIT) next_cycle();
    end
    // first of a pair is the address
    if (have_addr) begin
      exp_frames.push_back({pend_addr, data});
      have_addr = 1'b0;
    end else begin
      pend_addr = data;
      have_addr = 1'b1;
    end
    repeat (gap) next_cycle();
  endtask

  task automatic send_pairs(input int pairs);
    repeat (2 * pairs) send_host_byte(8'($urandom));
  endtask

  // reset pulse, then time the stretched panel reset
  task automatic pulse_reset(input int cycles);
    int low_cycles;
    have_addr       = 1'b0;
    reset_all_cmd_w = 1'b1;
    repeat (cycles) begin
      next_cycle();
      check_eq(32'(sen_o), 32'd1, "sen_o in reset");
      check_eq(32'(sck_o), 32'd0, "sck_o in reset");
      check_eq(32'(uart_tx_o), 32'd1, "uart_tx_o in reset");
      check_eq(32'(slm_reset_n_o), 32'd0, "slm_reset_n_o in reset");
    end
    reset_all_cmd_w = 1'b0;
    low_cycles      = 0;
    #1;
    while (slm_reset_n_o == 1'b0 && low_cycles <= 2 * RESET_HOLD_CLKS) begin
      low_cycles++;
      next_cycle();
    end
    check_eq(low_cycles, RESET_HOLD_CLKS, "slm_reset_n_o low cycles after reset");
  endtask

  task automatic wait_until_drained();
    while (exp_frames.size() != 0 || exp_replies.size() != 0) next_cycle();
    // let the last stop bit finish
    repeat (2 * UART_CLKS_PER_BIT) next_cycle();
  endtask

  //////////////////////////////
  // panel model, mode 0 slave
  initial begin : panel_model
    logic [FRAME_W-1:0] reply;
    logic [FRAME_W-1:0] mosi;
    logic [FRAME_W-1:0] want;
    logic               prev_sen;
    logic               prev_sck;
    int                 rises;
    int                 falls;
    int                 low_clks;
    int                 out_idx;
    prev_sen = 1'b1;
    prev_sck = 1'b0;
    forever begin
      next_cycle();
      // enable dropped, first reply bit out
      if (prev_sen && !sen_o) begin
        reply    = 16'($urandom);
        mosi     = '0;
        rises    = 0;
        falls    = 0;
        low_clks = 0;
        out_idx  = FRAME_W - 1;
        sout_i   = reply[out_idx];
        exp_replies.push_back(reply[BYTE_W-1:0]);
      end
      if (!sen_o) begin
        low_clks++;
        if (sck_o && !prev_sck) begin
          mosi = {mosi[FRAME_W-2:0], sdat_o};
          rises++;
        end
        // next bit after falling sck
        if (!sck_o && prev_sck) begin
          falls++;
          if (out_idx > 0) begin
            out_idx--;
            sout_i = reply[out_idx];
          end
        end
      end
      if (!prev_sen && sen_o) begin
        check_eq(rises, FRAME_W, "rising sck edges in frame");
        check_eq(falls, FRAME_W, "falling sck edges in frame");
        check_eq(low_clks, FRAME_CLKS, "sen_o low cycles");
        if (exp_frames.size() == 0) begin
          $display("SPI frame seen on sen_o with no host byte pair to match it");
          stop_with_failure();
        end else begin
          want = exp_frames.pop_front();
          check_eq(32'(mosi), 32'(want), "SPI frame bits");
        end
        frames_seen++;
      end
      prev_sen = sen_o;
      prev_sck = sck_o;
    end
  end

  //////////////////////////////
  // host side UART receiver
  initial begin : reply_receiver
    logic [BYTE_W-1:0] rx;
    logic [BYTE_W-1:0] want;
    forever begin
      next_cycle();
      if (uart_tx_o === 1'b0) begin
        // middle of start bit
        repeat (UART_CLKS_PER_BIT / 2) next_cycle();
        check_eq(32'(uart_tx_o), 32'd0, "uart_tx_o start bit");
        for (int i = 0; i < BYTE_W; i++) begin
          repeat (UART_CLKS_PER_BIT) next_cycle();
          rx = {uart_tx_o, rx[BYTE_W-1:1]};
        end
        repeat (UART_CLKS_PER_BIT) next_cycle();
        check_eq(32'(uart_tx_o), 32'd1, "uart_tx_o stop bit");
        if (exp_replies.size() == 0) begin
          $display("Reply byte on uart_tx_o with no SPI frame behind it");
          stop_with_failure();
        end else begin
          want = exp_replies.pop_front();
          check_eq(32'(rx), 32'(want), "reply byte on uart_tx_o");
        end
      end
    end
  end

  // watchdog and bound assertion count
  initial begin : watchdog
    int cycle_cnt;
    cycle_cnt = 0;
    forever begin
      @(posedge fpga_clk);
      cycle_cnt++;
      if (assert_failures() != 0) begin
        $display("A bound assertion failed, see the message above");
        stop_with_failure();
      end
      if (cycle_cnt > CYCLE_LIMIT) begin
        $display("Timeout after %0d cycles with traffic still pending", cycle_cnt);
        stop_with_failure();
      end
    end
  end

  //////////////////////////////
  // test sequence
  initial begin : main_seq
    int frames_before;
    void'($urandom(SEED));
    uart_rx_i       = 1'b1;
    sout_i          = 1'b0;
    reset_all_cmd_w = 1'b1;
    have_addr       = 1'b0;
    pend_addr       = '0;
    pulse_reset(4);
    send_pairs(8);
    // lone byte holds until its partner
    frames_before = frames_seen;
    send_host_byte(8'($urandom));
    repeat (3 * BYTE_CLKS) next_cycle();
    check_eq(frames_seen, frames_before, "frames sent with one byte pending");
    send_host_byte(8'($urandom));
    send_pairs(6);
    wait_until_drained();
    // pending address is lost on reset
    send_host_byte(8'($urandom));
    wait_until_drained();
    pulse_reset(2);
    send_pairs(8);
    wait_until_drained();
    if (assert_failures() == 0) begin
      $display("TEST PASS");
      $finish;
    end else begin
      $display("A bound assertion failed during the run");
      stop_with_failure();
    end
  end

endmodule

`default_nettype wire

// ==== holo_ctrl_top.f ====
holo_ctrl_pkg.sv
spi_xfer_if.sv
uart_rx.sv
uart_tx.sv
cmd_pairing.sv
spi_master.sv
reply_queue.sv
panel_reset.sv
holo_ctrl_top.sv
holo_ctrl_chk.sv
tb_holo_ctrl.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the holo_ctrl testbench with Verilator
# passes only when the log holds the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_holo_ctrl -f holo_ctrl_top.f \
  -o sim_holo_ctrl > build.log 2>&1 \
  && ./obj_dir/sim_holo_ctrl > sim.log 2>&1 \
  && grep -q "^TEST PASS$" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see build.log and sim.log"; exit 1; }
